/* kb_mmio.f */
+incdir+test
rtl/kb_mmio_pkg.sv
rtl/ps2_kb.sv
rtl/char_queue.sv
rtl/mmio_regs.sv
rtl/kb_mmio_top.sv
test/tb_kb_mmio.sv

/* rtl/char_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module char_queue #(
  parameter int QUEUE_DEPTH = 8   // Power of two, 2 to 128
) (
  input  logic                                VGA_VS,
  input  logic                                rst_n,
  input  logic                                kb_rdy_i,
  input  logic                                kb_make_i,
  input  logic [kb_mmio_pkg::ENTRY_WIDTH-1:0] kb_entry_i,
  input  logic                                q_pop_i,
  output logic [kb_mmio_pkg::ENTRY_WIDTH-1:0] q_head_o,
  output logic                                q_empty_o,
  output logic                                q_full_o,
  output logic [kb_mmio_pkg::COUNT_WIDTH-1:0] q_count_o
);
  import kb_mmio_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  logic [ENTRY_WIDTH-1:0] mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   do_wr;
  logic                   do_rd;

  // Releases never enter, full queue drops
  assign do_wr = kb_rdy_i & kb_make_i & ~q_full_o;
  assign do_rd = q_pop_i & ~q_empty_o;

  // Storage
  always_ff @(posedge VGA_VS) begin
    if (do_wr) mem[wr_ptr] <= kb_entry_i;
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VGA_VS or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + PTR_W'(1);  // Wraps at depth
      if (do_rd) rd_ptr <= rd_ptr + PTR_W'(1);
      case ({do_wr, do_rd})
        2'b10:   count <= count + COUNT_WIDTH'(1);
        2'b01:   count <= count - COUNT_WIDTH'(1);
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign q_head_o  = mem[rd_ptr];  // Show-ahead head
  assign q_empty_o = (count == '0);
  assign q_full_o  = (count == COUNT_WIDTH'(QUEUE_DEPTH));
  assign q_count_o = count;

  // Register side must check empty before popping
  a_no_pop_empty: assert property (@(posedge VGA_VS) disable iff (!rst_n)
    q_pop_i |-> !q_empty_o)
    else $error("pop requested on empty queue");

  a_count_bound: assert property (@(posedge VGA_VS) disable iff (!rst_n)
    q_count_o <= COUNT_WIDTH'(QUEUE_DEPTH))
    else $error("queue count above depth");

endmodule

`default_nettype wire

/* rtl/kb_mmio_pkg.sv */
`default_nettype none

package kb_mmio_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and entry widths
  ////////////////////////////////////////////////////////////
  parameter int DATA_WIDTH  = 32;  // Processor data bus
  parameter int ADDR_WIDTH  = 16;  // Peripheral address bus
  parameter int SC_WIDTH    = 8;   // One PS/2 scan code
  parameter int ENTRY_WIDTH = 10;  // Scan code plus two flags
  parameter int COUNT_WIDTH = 8;   // Queue occupancy, up to 128 entries

  // Flag positions inside a queue entry
  parameter int ENT_EXT_BIT   = 8;  // Code came after E0
  parameter int ENT_SHIFT_BIT = 9;  // A shift key was held

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////
  parameter logic [ADDR_WIDTH-1:0] ADDR_KB_CHAR   = 16'hFF00; // Head entry, pops on read
  parameter logic [ADDR_WIDTH-1:0] ADDR_KB_STATUS = 16'hFF04; // Queue status, no pop
  parameter logic [ADDR_WIDTH-1:0] ADDR_TIMER     = 16'hFF08; // Free-running cycle count
  parameter logic [ADDR_WIDTH-1:0] ADDR_CONFIG    = 16'hFF0C; // Display mode in bit 0

  // Status word layout
  parameter int STAT_EMPTY_BIT = 0;
  parameter int STAT_FULL_BIT  = 1;
  parameter int STAT_PERR_BIT  = 2;  // Sticky until reset
  parameter int STAT_COUNT_LSB = 8;  // Count sits in bits 15:8

  ////////////////////////////////////////////////////////////
  // PS/2 set 2 scan codes
  ////////////////////////////////////////////////////////////
  parameter logic [SC_WIDTH-1:0] SC_BREAK  = 8'hF0;  // Release prefix
  parameter logic [SC_WIDTH-1:0] SC_EXT    = 8'hE0;  // Extended prefix
  parameter logic [SC_WIDTH-1:0] SC_LSHIFT = 8'h12;
  parameter logic [SC_WIDTH-1:0] SC_RSHIFT = 8'h59;

endpackage

`default_nettype wire

/* rtl/kb_mmio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module kb_mmio_top #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                               VGA_VS,
  input  logic                               rst_n,
  input  logic                               ps2_clk_i,
  input  logic                               ps2_dat_i,
  input  logic                               bus_re_i,
  input  logic                               bus_we_i,
  input  logic [kb_mmio_pkg::ADDR_WIDTH-1:0] bus_addr_i,
  input  logic [kb_mmio_pkg::DATA_WIDTH-1:0] bus_wdata_i,
  output logic [kb_mmio_pkg::DATA_WIDTH-1:0] bus_rdata_o,
  output logic                               perr_o,
  output logic                               mode_o
);
  import kb_mmio_pkg::*;

  // Keyboard to queue
  logic [ENTRY_WIDTH-1:0] kb_entry;
  logic                   kb_rdy;
  logic                   kb_make;
  // Queue to register port
  logic [ENTRY_WIDTH-1:0] q_head;
  logic                   q_empty;
  logic                   q_full;
  logic [COUNT_WIDTH-1:0] q_count;
  logic                   q_pop;

  ////////////////////////////////////////////////////////////
  // Producer, buffer, consumer
  ////////////////////////////////////////////////////////////
  ps2_kb ps2_kb_i (
    .VGA_VS     (VGA_VS),
    .rst_n      (rst_n),
    .ps2_clk_i  (ps2_clk_i),
    .ps2_dat_i  (ps2_dat_i),
    .kb_entry_o (kb_entry),
    .kb_rdy_o   (kb_rdy),
    .kb_make_o  (kb_make),
    .perr_o     (perr_o)      // Also feeds the status word
  );

  char_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) char_queue_i (
    .VGA_VS     (VGA_VS),
    .rst_n      (rst_n),
    .kb_rdy_i   (kb_rdy),
    .kb_make_i  (kb_make),
    .kb_entry_i (kb_entry),
    .q_pop_i    (q_pop),
    .q_head_o   (q_head),
    .q_empty_o  (q_empty),
    .q_full_o   (q_full),
    .q_count_o  (q_count)
  );

  mmio_regs mmio_regs_i (
    .VGA_VS      (VGA_VS),
    .rst_n       (rst_n),
    .bus_re_i    (bus_re_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .q_head_i    (q_head),
    .q_empty_i   (q_empty),
    .q_full_i    (q_full),
    .q_count_i   (q_count),
    .perr_i      (perr_o),
    .bus_rdata_o (bus_rdata_o),
    .q_pop_o     (q_pop),
    .mode_o      (mode_o)
  );

endmodule

`default_nettype wire

/* rtl/mmio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_regs (
  input  logic                                VGA_VS,
  input  logic                                rst_n,
  input  logic                                bus_re_i,
  input  logic                                bus_we_i,
  input  logic [kb_mmio_pkg::ADDR_WIDTH-1:0]  bus_addr_i,
  input  logic [kb_mmio_pkg::DATA_WIDTH-1:0]  bus_wdata_i,
  input  logic [kb_mmio_pkg::ENTRY_WIDTH-1:0] q_head_i,
  input  logic                                q_empty_i,
  input  logic                                q_full_i,
  input  logic [kb_mmio_pkg::COUNT_WIDTH-1:0] q_count_i,
  input  logic                                perr_i,
  output logic [kb_mmio_pkg::DATA_WIDTH-1:0]  bus_rdata_o,
  output logic                                q_pop_o,
  output logic                                mode_o
);
  import kb_mmio_pkg::*;

  logic [DATA_WIDTH-1:0] timer;
  logic [DATA_WIDTH-1:0] status_word;
  logic [DATA_WIDTH-1:0] char_word;
  logic [DATA_WIDTH-1:0] rd_mux;
  logic                  hit_char;
  logic                  hit_config;

  assign hit_char   = (bus_addr_i == ADDR_KB_CHAR);
  assign hit_config = (bus_addr_i == ADDR_CONFIG);

  // Pop in the same cycle the head is captured
  assign q_pop_o = bus_re_i & hit_char & ~q_empty_i;

  ////////////////////////////////////////////////////////////
  // Cycle timer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VGA_VS or negedge rst_n) begin
    if (!rst_n) timer <= '0;
    else        timer <= timer + DATA_WIDTH'(1);  // Free running, wraps
  end

  // Status and character words
  always_comb begin
    status_word                                   = '0;
    status_word[STAT_EMPTY_BIT]                   = q_empty_i;
    status_word[STAT_FULL_BIT]                    = q_full_i;
    status_word[STAT_PERR_BIT]                    = perr_i;
    status_word[STAT_COUNT_LSB +: COUNT_WIDTH]    = q_count_i;
  end

  assign char_word = q_empty_i ? '0 : DATA_WIDTH'(q_head_i);  // Zero when nothing queued

  // Read decode
  always_comb begin
    case (bus_addr_i)
      ADDR_KB_CHAR:   rd_mux = char_word;
      ADDR_KB_STATUS: rd_mux = status_word;
      ADDR_TIMER:     rd_mux = timer;                 // Value in the request cycle
      ADDR_CONFIG:    rd_mux = DATA_WIDTH'(mode_o);
      default:        rd_mux = '0;                    // Unmapped
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Read data and mode registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VGA_VS or negedge rst_n) begin
    if (!rst_n) begin
      bus_rdata_o <= '0;
      mode_o      <= 1'b0;
    end else begin
      if (bus_re_i) bus_rdata_o <= rd_mux;               // Held until next read
      if (bus_we_i && hit_config) mode_o <= bus_wdata_i[0];
    end
  end

  // Bus master issues one access per cycle
  a_rw_excl: assert property (@(posedge VGA_VS) disable iff (!rst_n)
    !(bus_re_i && bus_we_i))
    else $error("read and write strobes together");

endmodule

`default_nettype wire

/* rtl/ps2_kb.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_kb (
  input  logic                                VGA_VS,
  input  logic                                rst_n,
  input  logic                                ps2_clk_i,   // Keyboard drives its own clock
  input  logic                                ps2_dat_i,
  output logic [kb_mmio_pkg::ENTRY_WIDTH-1:0] kb_entry_o,
  output logic                                kb_rdy_o,    // One-cycle strobe
  output logic                                kb_make_o,   // Valid while kb_rdy_o is high
  output logic                                perr_o       // Sticky parity error
);
  import kb_mmio_pkg::*;

  localparam int          FRAME_BITS = 11;       // Start, 8 data, parity, stop
  localparam logic [11:0] STALL_MAX  = 12'd2048; // Give up on a half-received frame

  logic [2:0]            clk_sync;   // Two sync stages plus edge history
  logic [1:0]            dat_sync;
  logic                  clk_fall;
  logic [3:0]            bit_cnt;
  logic [11:0]           stall_cnt;
  logic [FRAME_BITS-1:0] frame;
  logic                  frame_done;
  logic [SC_WIDTH-1:0]   code;
  logic                  par_ok;
  logic                  frm_ok;
  logic                  is_prefix;
  logic                  code_ok;
  logic                  emit;
  logic                  ext_pend;    // E0 seen, applies to next code
  logic                  brk_pend;    // F0 seen, next code is a release
  logic                  lshift_held;
  logic                  rshift_held;

  ////////////////////////////////////////////////////////////
  // Synchronizers and falling-edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VGA_VS or negedge rst_n) begin
    if (!rst_n) begin
      clk_sync <= 3'b111;  // Both lines idle high
      dat_sync <= 2'b11;
    end else begin
      clk_sync <= {clk_sync[1:0], ps2_clk_i};
      dat_sync <= {dat_sync[0], ps2_dat_i};
    end
  end

  assign clk_fall = clk_sync[2] & ~clk_sync[1];

  // Bit counter with stall timeout
  always_ff @(posedge VGA_VS or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      stall_cnt  <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (clk_fall) begin
        stall_cnt <= '0;
        if (bit_cnt == 4'(FRAME_BITS - 1)) begin
          bit_cnt    <= '0;
          frame_done <= 1'b1;  // Stop bit just shifted in
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (bit_cnt != '0) begin
        if (stall_cnt == STALL_MAX) begin
          bit_cnt   <= '0;     // Keyboard went quiet mid-frame
          stall_cnt <= '0;
        end else begin
          stall_cnt <= stall_cnt + 12'd1;
        end
      end
    end
  end

  // LSB first, stop bit ends up in the top position
  always_ff @(posedge VGA_VS) begin
    if (clk_fall) begin
      frame <= {dat_sync[1], frame[FRAME_BITS-1:1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Frame check and prefix tracking
  ////////////////////////////////////////////////////////////
  assign code      = frame[8:1];
  assign par_ok    = ^frame[9:1];             // Odd parity across data and parity bit
  assign frm_ok    = ~frame[0] & frame[10];   // Start low, stop high
  assign is_prefix = (code == SC_EXT) || (code == SC_BREAK);
  assign code_ok   = frame_done & frm_ok & par_ok;
  assign emit      = code_ok & ~is_prefix;

  always_ff @(posedge VGA_VS or negedge rst_n) begin
    if (!rst_n) begin
      ext_pend    <= 1'b0;
      brk_pend    <= 1'b0;
      lshift_held <= 1'b0;
      rshift_held <= 1'b0;
      kb_rdy_o    <= 1'b0;
      kb_make_o   <= 1'b0;
      perr_o      <= 1'b0;
    end else begin
      kb_rdy_o <= emit;
      if (frame_done && !par_ok) perr_o <= 1'b1;   // Stays set until reset
      if (code_ok && code == SC_EXT) ext_pend <= 1'b1;
      if (code_ok && code == SC_BREAK) brk_pend <= 1'b1;
      if (emit) begin
        kb_make_o <= ~brk_pend;
        ext_pend  <= 1'b0;  // Prefixes apply to one code only
        brk_pend  <= 1'b0;
        if (code == SC_LSHIFT) lshift_held <= ~brk_pend;
        if (code == SC_RSHIFT) rshift_held <= ~brk_pend;
      end
    end
  end

  // Entry payload, shift flag reflects state before this code
  always_ff @(posedge VGA_VS) begin
    if (emit) begin
      kb_entry_o[SC_WIDTH-1:0]  <= code;
      kb_entry_o[ENT_EXT_BIT]   <= ext_pend;
      kb_entry_o[ENT_SHIFT_BIT] <= lshift_held | rshift_held;
    end
  end

  // Frames are far longer than one cycle
  a_rdy_pulse: assert property (@(posedge VGA_VS) disable iff (!rst_n)
    kb_rdy_o |=> !kb_rdy_o)
    else $error("kb_rdy held for two cycles");

  a_make_known: assert property (@(posedge VGA_VS) disable iff (!rst_n)
    kb_rdy_o |-> !$isunknown(kb_make_o))
    else $error("kb_make unknown during ready");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the keyboard MMIO testbench with Verilator, run it, check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f kb_mmio.f --top-module tb_kb_mmio -Mdir obj_dir
./obj_dir/Vtb_kb_mmio | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

/* test/tb_ps2_tasks.svh */
`ifndef TB_PS2_TASKS_SVH
`define TB_PS2_TASKS_SVH

//////////////////////////////////////////////////////////////
// Timing helpers and PS/2 serializer
//////////////////////////////////////////////////////////////
task automatic idle_cycles(input int n);
  repeat (n) @(posedge VGA_VS);
  #2;  // Drive point after the edge
endtask

// Data changes while the keyboard clock is high
task automatic clock_bit(input logic b);
  ps2_dat = b;
  idle_cycles(PS2_HALF);
  ps2_clk = 1'b0;
  idle_cycles(PS2_HALF);
  ps2_clk = 1'b1;
endtask

// Start, data LSB first, parity, then stop bit held just before its edge
task automatic frame_to_stop(input logic [7:0] code, input logic bad_par);
  logic par;
  int   i;
  par = ~^code ^ bad_par;  // Odd parity, flipped on request
  clock_bit(1'b0);
  for (i = 0; i < 8; i++) clock_bit(code[i]);
  clock_bit(par);
  ps2_dat = 1'b1;
  idle_cycles(PS2_HALF);
endtask

task automatic send_byte(input logic [7:0] code, input logic bad_par);
  frame_to_stop(code, bad_par);
  ps2_clk = 1'b0;          // Stop-bit edge
  idle_cycles(PS2_HALF);
  ps2_clk = 1'b1;
  idle_cycles(PS2_HALF);   // Line idle between frames
endtask

//////////////////////////////////////////////////////////////
// Bus side
//////////////////////////////////////////////////////////////
task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
  bus_addr = addr;
  bus_re   = 1'b1;
  idle_cycles(1);
  bus_re   = 1'b0;
  data     = bus_rdata;  // Registered at the edge just passed
endtask

task automatic bus_write(input logic [15:0] addr, input logic [31:0] wdata);
  bus_addr  = addr;
  bus_wdata = wdata;
  bus_we    = 1'b1;
  idle_cycles(1);
  bus_we    = 1'b0;
endtask

// Poll status until the count field reaches n
task automatic wait_count(input int n);
  logic [31:0] st;
  int          tries;
  tries = 0;
  do begin
    bus_read(ADDR_KB_STATUS, st);
    tries++;
  end while (int'(st[STAT_COUNT_LSB +: COUNT_WIDTH]) != n && tries < WAIT_LIMIT);
  if (int'(st[STAT_COUNT_LSB +: COUNT_WIDTH]) != n) begin
    errors++;
    $display("Timed out waiting for a queue count of %0d", n);
  end
endtask

`endif

/* test/tb_kb_mmio.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_kb_mmio;
  import kb_mmio_pkg::*;

  localparam int          QDEPTH     = 8;
  localparam int          PS2_HALF   = 6;   // System cycles per PS/2 half period
  localparam int          WAIT_LIMIT = 40;
  localparam logic [31:0] SEED       = 32'hdf10_743c;

  logic                   VGA_VS;
  logic                   rst_n;
  logic                   ps2_clk;
  logic                   ps2_dat;
  logic                   bus_re;
  logic                   bus_we;
  logic [ADDR_WIDTH-1:0]  bus_addr;
  logic [DATA_WIDTH-1:0]  bus_wdata;
  logic [DATA_WIDTH-1:0]  bus_rdata;
  logic                   perr;
  logic                   mode;
  int                     errors = 0;
  logic [ENTRY_WIDTH-1:0] model_q[$];  // Expected entries in arrival order
  logic                   shift_dn = 1'b0;

  `include "tb_ps2_tasks.svh"

  kb_mmio_top #(.QUEUE_DEPTH(QDEPTH)) kb_mmio_i (
    .VGA_VS(VGA_VS), .rst_n(rst_n), .ps2_clk_i(ps2_clk), .ps2_dat_i(ps2_dat),
    .bus_re_i(bus_re), .bus_we_i(bus_we), .bus_addr_i(bus_addr),
    .bus_wdata_i(bus_wdata), .bus_rdata_o(bus_rdata), .perr_o(perr), .mode_o(mode)
  );

  initial begin
    VGA_VS = 1'b0;
    forever #20 VGA_VS = ~VGA_VS;
  end

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want)
      else begin
        errors++;
        $display("ERROR %s got 0x%h exp 0x%h", name, got, want);
      end
  endtask

  function automatic logic [7:0] rand_code();
    logic [7:0] c;
    do begin
      c = 8'($urandom);
    end while (c == SC_BREAK || c == SC_EXT || c == SC_LSHIFT || c == SC_RSHIFT);
    return c;
  endfunction

  // Shift flag is the shift state before this key
  task automatic key_make(input logic [7:0] code, input logic ext);
    if (ext) send_byte(SC_EXT, 1'b0);
    send_byte(code, 1'b0);
    if (model_q.size() < QDEPTH) model_q.push_back({shift_dn, ext, code});  // Full drops
    if (code == SC_LSHIFT || code == SC_RSHIFT) shift_dn = 1'b1;
  endtask

  task automatic key_break(input logic [7:0] code);
    send_byte(SC_BREAK, 1'b0);
    send_byte(code, 1'b0);
    if (code == SC_LSHIFT || code == SC_RSHIFT) shift_dn = 1'b0;
  endtask

  task automatic pop_check();
    logic [31:0]            rd;
    logic [ENTRY_WIDTH-1:0] want;
    want = model_q.pop_front();
    bus_read(ADDR_KB_CHAR, rd);
    expect_eq("bus_rdata", rd, {22'd0, want});
  endtask

  //////////////////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////////////////
  a_mode_follow: assert property (@(posedge VGA_VS) disable iff (!rst_n)
    (bus_we && bus_addr == ADDR_CONFIG) |=> (mode == $past(bus_wdata[0])))
    else begin
      errors++;
      $display("ERROR mode got 0x%h after a config write", mode);
    end

  a_perr_sticky: assert property (@(posedge VGA_VS) disable iff (!rst_n)
    perr |=> perr)
    else begin
      errors++;
      $display("ERROR perr got 0x0 exp 0x1, parity flag dropped");
    end

  initial begin
    logic [31:0] rd;
    logic [31:0] t1;
    logic [7:0]  c;
    int          k;
    int          lat;
    void'($urandom(SEED));
    rst_n     = 1'b0;
    ps2_clk   = 1'b1;   // PS/2 lines idle high
    ps2_dat   = 1'b1;
    bus_re    = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    idle_cycles(4);
    rst_n = 1'b1;
    expect_eq("bus_rdata", bus_rdata, 32'd0);
    expect_eq("mode", 32'(mode), 32'd0);
    bus_read(ADDR_KB_STATUS, rd);
    expect_eq("bus_rdata", rd, 32'h1);   // Empty only

    // Plain make codes in order
    repeat (3) key_make(rand_code(), 1'b0);
    wait_count(3);
    repeat (3) pop_check();
    bus_read(ADDR_KB_STATUS, rd);
    expect_eq("bus_rdata", rd, 32'h1);

    // Break, extended, shift held and released
    key_break(rand_code());
    bus_read(ADDR_KB_STATUS, rd);
    expect_eq("bus_rdata", rd, 32'h1);  // Release adds nothing
    key_make(rand_code(), 1'b1);
    key_make(SC_LSHIFT, 1'b0);
    key_make(rand_code(), 1'b0);
    key_break(SC_LSHIFT);
    key_make(rand_code(), 1'b0);
    wait_count(4);
    repeat (4) pop_check();

    // Bad parity
    send_byte(rand_code(), 1'b1);
    bus_read(ADDR_KB_STATUS, rd);
    expect_eq("bus_rdata", rd, 32'h5);  // Empty plus perr
    expect_eq("perr", 32'(perr), 32'd1);

    ////////////////////////////////////////////////////////////
    // Stop edge to status count with a status read every cycle
    ////////////////////////////////////////////////////////////
    c = rand_code();
    frame_to_stop(c, 1'b0);
    ps2_clk  = 1'b0;
    bus_addr = ADDR_KB_STATUS;
    bus_re   = 1'b1;
    lat      = -1;
    for (k = 1; k <= WAIT_LIMIT && lat < 0; k++) begin
      @(posedge VGA_VS);
      #1;
      if (bus_rdata[STAT_COUNT_LSB +: COUNT_WIDTH] != '0) lat = k - 1;  // Cycle sampled
    end
    #1;
    bus_re = 1'b0;
    if (lat < 0) begin
      errors++;
      $display("Timed out waiting for the entry after the stop-bit edge");
    end else begin
      expect_eq("latency", 32'(lat), 32'd5);
    end
    idle_cycles(PS2_HALF);
    ps2_clk = 1'b1;
    idle_cycles(PS2_HALF);
    model_q.push_back({shift_dn, 1'b0, c});
    pop_check();

    // Overfill drops the last two
    repeat (QDEPTH + 2) key_make(rand_code(), 1'b0);
    wait_count(QDEPTH);
    bus_read(ADDR_KB_STATUS, rd);
    expect_eq("bus_rdata", rd, {16'd0, 8'(QDEPTH), 8'h06});
    repeat (QDEPTH) pop_check();
    bus_read(ADDR_KB_CHAR, rd);
    expect_eq("bus_rdata", rd, 32'd0);
    bus_read(ADDR_KB_STATUS, rd);
    expect_eq("bus_rdata", rd, 32'h5);

    // Timer delta and config bit
    k = 2 + int'($urandom % 30);
    bus_read(ADDR_TIMER, t1);
    idle_cycles(k - 1);
    bus_read(ADDR_TIMER, rd);
    expect_eq("timer delta", rd - t1, 32'(k));
    bus_write(ADDR_CONFIG, 32'd1);
    expect_eq("mode", 32'(mode), 32'd1);
    bus_read(ADDR_CONFIG, rd);
    expect_eq("bus_rdata", rd, 32'd1);
    bus_write(ADDR_CONFIG, 32'd0);
    expect_eq("mode", 32'(mode), 32'd0);
    bus_read(16'h0010, rd);             // Unmapped
    expect_eq("bus_rdata", rd, 32'd0);

    // Parity flag held until reset
    expect_eq("perr", 32'(perr), 32'd1);
    bus_write(ADDR_CONFIG, 32'd1);      // Mode and read data nonzero going into reset
    bus_read(ADDR_KB_STATUS, rd);
    expect_eq("bus_rdata", rd, 32'h5);
    rst_n = 1'b0;
    idle_cycles(2);
    expect_eq("perr", 32'(perr), 32'd0);
    expect_eq("mode", 32'(mode), 32'd0);
    expect_eq("bus_rdata", bus_rdata, 32'd0);
    rst_n = 1'b1;
    idle_cycles(2);
    bus_read(ADDR_KB_STATUS, rd);
    expect_eq("bus_rdata", rd, 32'h1);  // Parity bit cleared

    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
